//--- rtl/ann_cfg.svh
`ifndef ANN_CFG_SVH
`define ANN_CFG_SVH

// Q8.8 signed values
`define ANN_DATA_W 16
`define ANN_FRAC_W 8

// products and running sums
`define ANN_ACC_W 32

// network shape
`define ANN_N_IN 2
`define ANN_N_HID 4
`define ANN_N_OUT 3

// 12 hidden weights, 15 output weights
`define ANN_WADDR_W 4

// wide enough for the largest layer
`define ANN_NODE_W 2

`endif

//--- rtl/ann_pkg.sv
`default_nettype none

`include "ann_cfg.svh"

package ann_pkg;

	typedef logic signed [`ANN_DATA_W-1:0] act_t;
	typedef logic signed [`ANN_DATA_W-1:0] weight_t;
	typedef logic signed [`ANN_ACC_W-1:0] acc_t;

	typedef enum logic {
		LAYER_HIDDEN = 1'b0,
		LAYER_OUTPUT = 1'b1
	} layer_e;

	typedef logic [`ANN_WADDR_W-1:0] waddr_t;
	typedef logic [`ANN_NODE_W-1:0] node_t;

	typedef struct packed {
		logic valid;
		layer_e layer;
		waddr_t waddr;
		weight_t value;
	} weight_wr_t;

	typedef struct packed {
		logic valid;
		node_t node;
		act_t value;
	} input_wr_t;

	typedef struct packed {
		logic valid;
		layer_e layer;
		waddr_t waddr;
	} weight_rd_t;

	typedef struct packed {
		logic valid;
		layer_e layer;
		waddr_t waddr;
		weight_t value;
	} weight_rsp_t;

	// engine side weight fetch
	typedef struct packed {
		logic valid;
		layer_e layer;
		waddr_t waddr;
	} wreq_t;

	// one output node from the engine
	typedef struct packed {
		logic valid;
		node_t node;
		act_t value;
	} node_out_t;

	typedef struct packed {
		logic valid;
		node_t arg_max;
		act_t value;
	} result_t;

endpackage

`default_nettype wire

//--- rtl/ann_ram.sv
`timescale 1ns/100ps
`default_nettype none

module ann_ram #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 16
) (
	input wire logic clk,
	input wire logic i_we,
	input wire logic [((depth > 1) ? $clog2(depth) : 1)-1:0] i_waddr,
	input wire payload_t i_wdata,
	input wire logic i_re,
	input wire logic [((depth > 1) ? $clog2(depth) : 1)-1:0] i_raddr,
	output payload_t o_rdata
);

	payload_t mem [depth];

	// write lands at the edge, read next cycle sees it
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (i_re) begin
			o_rdata <= mem[i_raddr]; // holds last value otherwise
		end
	end

endmodule

`default_nettype wire

//--- rtl/ann_host_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "ann_cfg.svh"

module ann_host_port (
	input wire logic clk,
	input wire logic rst_n,
	input wire ann_pkg::weight_wr_t i_weight_wr,
	input wire ann_pkg::input_wr_t i_input_wr,
	input wire ann_pkg::weight_rd_t i_weight_rd,
	input wire logic i_busy,
	input wire ann_pkg::wreq_t i_wreq,
	input wire ann_pkg::node_t i_in_idx,
	output ann_pkg::weight_t o_weight,
	output ann_pkg::act_t o_in_act,
	output ann_pkg::weight_rsp_t o_weight_rsp
);
	import ann_pkg::*;

	localparam int wram_aw = `ANN_WADDR_W + 1; // layer bit on top of index

	logic w_we;
	logic [wram_aw-1:0] w_waddr;
	logic w_re;
	logic [wram_aw-1:0] w_raddr;
	logic in_we;
	weight_rd_t tag_q;

	assign w_we = i_weight_wr.valid && !i_busy;
	assign w_waddr = {i_weight_wr.layer, i_weight_wr.waddr};
	// engine owns the read port during inference
	assign w_re = i_busy ? i_wreq.valid : i_weight_rd.valid;
	assign w_raddr = i_busy ? {i_wreq.layer, i_wreq.waddr} : {i_weight_rd.layer, i_weight_rd.waddr};
	assign in_we = i_input_wr.valid && !i_busy;

	ann_ram #(.payload_t(weight_t), .depth(1 << wram_aw)) weight_ram_inst (
		.clk(clk),
		.i_we(w_we),
		.i_waddr(w_waddr),
		.i_wdata(i_weight_wr.value),
		.i_re(w_re),
		.i_raddr(w_raddr),
		.o_rdata(o_weight)
	);

	ann_ram #(.payload_t(act_t), .depth(1 << `ANN_NODE_W)) input_ram_inst (
		.clk(clk),
		.i_we(in_we),
		.i_waddr(i_input_wr.node),
		.i_wdata(i_input_wr.value),
		.i_re(i_busy),
		.i_raddr(i_in_idx),
		.o_rdata(o_in_act)
	);

	// tag follows the ram read, response one stage later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tag_q <= '0;
			o_weight_rsp <= '0;
		end else begin
			tag_q <= i_weight_rd;
			tag_q.valid <= i_weight_rd.valid && !i_busy; // dropped while busy
			o_weight_rsp.valid <= tag_q.valid;
			o_weight_rsp.layer <= tag_q.layer;
			o_weight_rsp.waddr <= tag_q.waddr;
			o_weight_rsp.value <= o_weight;
		end
	end

endmodule

`default_nettype wire

//--- rtl/ann_feed_forward.sv
`timescale 1ns/100ps
`default_nettype none

`include "ann_cfg.svh"

module ann_feed_forward (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic i_start,
	input wire ann_pkg::weight_t i_weight,
	input wire ann_pkg::act_t i_in_act,
	output ann_pkg::wreq_t o_wreq,
	output ann_pkg::node_t o_in_idx,
	output ann_pkg::node_out_t o_out,
	output logic o_busy
);
	import ann_pkg::*;

	localparam int k_w = $clog2(`ANN_N_HID + 1);
	localparam acc_t act_max = acc_t'((1 << (`ANN_DATA_W - 1)) - 1);
	localparam acc_t act_min = -act_max - 1;

	typedef enum logic [1:0] {ST_IDLE, ST_HIDDEN, ST_OUTPUT, ST_DRAIN} state_e;

	state_e state_q;
	node_t node_q;
	logic [k_w-1:0] k_q; // input index within node, last one is bias
	waddr_t waddr_q;
	logic issuing;
	logic last_k;
	logic last_node;
	layer_e cur_layer;

	logic s1_valid;
	logic s1_first;
	logic s1_bias;
	layer_e s1_layer;
	node_t s1_node;
	logic s2_valid;
	layer_e s2_layer;
	node_t s2_node;

	act_t act_in;
	act_t hid_rdata;
	acc_t prod;
	acc_t acc_q;
	acc_t sum_sh;
	act_t node_val;
	logic hid_we;

	assign issuing = (state_q == ST_HIDDEN) || (state_q == ST_OUTPUT);
	assign cur_layer = (state_q == ST_OUTPUT) ? LAYER_OUTPUT : LAYER_HIDDEN;
	assign last_k = (state_q == ST_OUTPUT) ? (k_q == k_w'(`ANN_N_HID)) : (k_q == k_w'(`ANN_N_IN));
	assign last_node = (state_q == ST_OUTPUT) ? (node_q == node_t'(`ANN_N_OUT - 1)) :
		(node_q == node_t'(`ANN_N_HID - 1));

	assign o_wreq = '{valid: issuing, layer: cur_layer, waddr: waddr_q};
	assign o_in_idx = node_t'(k_q); // bias slot reads a don't-care entry
	assign o_busy = (state_q != ST_IDLE);

	// weights of a layer are contiguous, so waddr just counts up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			node_q <= '0;
			k_q <= '0;
			waddr_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (i_start) begin
						state_q <= ST_HIDDEN;
					end
				end
				ST_HIDDEN, ST_OUTPUT: begin
					waddr_q <= waddr_q + 1'b1;
					k_q <= k_q + 1'b1;
					if (last_k) begin
						k_q <= '0;
						node_q <= node_q + 1'b1;
						if (last_node) begin
							node_q <= '0;
							waddr_q <= '0;
							state_q <= (state_q == ST_HIDDEN) ? ST_OUTPUT : ST_DRAIN;
						end
					end
				end
				ST_DRAIN: begin
					if (o_out.valid && (o_out.node == node_t'(`ANN_N_OUT - 1))) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// stage 1: weight and activation arrive, multiply and accumulate
	assign act_in = (s1_layer == LAYER_OUTPUT) ? hid_rdata : i_in_act;
	assign prod = s1_bias ? (acc_t'(i_weight) <<< `ANN_FRAC_W) : acc_t'(i_weight) * acc_t'(act_in);

	// stage 2: rescale, saturate, relu on hidden nodes
	always_comb begin
		sum_sh = acc_q >>> `ANN_FRAC_W;
		if (sum_sh > act_max) begin
			node_val = act_t'(act_max);
		end else if (sum_sh < act_min) begin
			node_val = act_t'(act_min);
		end else begin
			node_val = act_t'(sum_sh);
		end
		if ((s2_layer == LAYER_HIDDEN) && (node_val < 0)) begin
			node_val = '0;
		end
	end

	assign hid_we = s2_valid && (s2_layer == LAYER_HIDDEN);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			o_out <= '0;
		end else begin
			s1_valid <= issuing;
			s2_valid <= s1_valid && s1_bias; // bias closes the node
			o_out.valid <= s2_valid && (s2_layer == LAYER_OUTPUT);
			o_out.node <= s2_node;
			o_out.value <= node_val;
		end
	end

	always_ff @(posedge clk) begin
		s1_first <= (k_q == '0);
		s1_bias <= last_k;
		s1_layer <= cur_layer;
		s1_node <= node_q;
		s2_layer <= s1_layer;
		s2_node <= s1_node;
		if (s1_valid) begin
			acc_q <= s1_first ? prod : acc_q + prod;
		end
	end

	ann_ram #(.payload_t(act_t), .depth(1 << `ANN_NODE_W)) hidden_ram_inst (
		.clk(clk),
		.i_we(hid_we),
		.i_waddr(s2_node),
		.i_wdata(node_val),
		.i_re(state_q == ST_OUTPUT),
		.i_raddr(node_t'(k_q)),
		.o_rdata(hid_rdata)
	);

endmodule

`default_nettype wire

//--- rtl/ann_arg_max.sv
`timescale 1ns/100ps
`default_nettype none

`include "ann_cfg.svh"

module ann_arg_max (
	input wire logic clk,
	input wire logic rst_n,
	input wire ann_pkg::node_out_t i_out,
	output ann_pkg::result_t o_result
);
	import ann_pkg::*;

	act_t max_q;
	node_t idx_q;
	logic take;
	act_t cur_max;
	node_t cur_idx;

	// node 0 always seeds, strict compare keeps lowest index on ties
	assign take = (i_out.node == '0) || (i_out.value > max_q);
	assign cur_max = take ? i_out.value : max_q;
	assign cur_idx = take ? i_out.node : idx_q;

	always_ff @(posedge clk) begin
		if (i_out.valid) begin
			max_q <= cur_max;
			idx_q <= cur_idx;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_result <= '0;
		end else begin
			o_result.valid <= i_out.valid && (i_out.node == node_t'(`ANN_N_OUT - 1));
			o_result.arg_max <= cur_idx;
			o_result.value <= cur_max;
		end
	end

endmodule

`default_nettype wire

//--- rtl/main_net.sv
`timescale 1ns/100ps
`default_nettype none

module main_net (
	input wire logic clk,
	input wire logic rst_n,
	input wire ann_pkg::weight_wr_t i_weight_wr,
	input wire ann_pkg::input_wr_t i_input_wr,
	input wire logic i_start,
	input wire ann_pkg::weight_rd_t i_weight_rd,
	output ann_pkg::weight_rsp_t o_weight_rsp,
	output ann_pkg::result_t o_result,
	output logic o_busy
);
	import ann_pkg::*;

	wreq_t wreq;
	node_t in_idx;
	weight_t weight;
	act_t in_act;
	node_out_t node_out;

	ann_host_port host_port_inst (
		.clk(clk),
		.rst_n(rst_n),
		.i_weight_wr(i_weight_wr),
		.i_input_wr(i_input_wr),
		.i_weight_rd(i_weight_rd),
		.i_busy(o_busy), // engine busy steers the weight port
		.i_wreq(wreq),
		.i_in_idx(in_idx),
		.o_weight(weight),
		.o_in_act(in_act),
		.o_weight_rsp(o_weight_rsp)
	);

	ann_feed_forward feed_forward_inst (
		.clk(clk),
		.rst_n(rst_n),
		.i_start(i_start),
		.i_weight(weight),
		.i_in_act(in_act),
		.o_wreq(wreq),
		.o_in_idx(in_idx),
		.o_out(node_out),
		.o_busy(o_busy)
	);

	ann_arg_max arg_max_inst (
		.clk(clk),
		.rst_n(rst_n),
		.i_out(node_out),
		.o_result(o_result)
	);

endmodule

`default_nettype wire

//--- dv/main_net_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "ann_cfg.svh"

module main_net_checker (
	input wire logic clk,
	input wire logic rst_n,
	input wire ann_pkg::weight_rd_t i_weight_rd,
	input wire ann_pkg::weight_rsp_t i_weight_rsp,
	input wire ann_pkg::result_t i_result,
	input wire logic i_busy
);

	int n_fail = 0;

	// result closes the busy window
	a_result_idle: assert property (@(posedge clk) disable iff (!rst_n)
		i_result.valid |-> !i_busy)
		else begin
			n_fail++;
			$error("o_busy high together with a result");
		end

	a_arg_max_range: assert property (@(posedge clk) disable iff (!rst_n)
		i_result.valid |-> (i_result.arg_max < `ANN_N_OUT))
		else begin
			n_fail++;
			$error("arg max node out of range");
		end

	a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
		i_weight_rsp.valid |-> $past(i_weight_rd.valid, 2)) // ram plus response stage
		else begin
			n_fail++;
			$error("readback response without a request two cycles before");
		end

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> !(i_busy || i_result.valid || i_weight_rsp.valid))
		else begin
			n_fail++;
			$error("output valid during reset");
		end

endmodule

`default_nettype wire

//--- dv/main_net_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "ann_cfg.svh"

module main_net_tb;
	import ann_pkg::*;

	localparam int n_hid_w = `ANN_N_HID * (`ANN_N_IN + 1);
	localparam int n_out_w = `ANN_N_OUT * (`ANN_N_HID + 1);
	localparam int n_rows = 7;
	localparam int infer_cycles = n_hid_w + n_out_w + 6; // issue, pipeline, result
	localparam int test_cycles = 20 + 3 * (n_hid_w + n_out_w) + 4 * n_rows + 12
		+ (n_rows + 2) * (infer_cycles + 4);
	localparam int cycle_limit = 2 * test_cycles;
	localparam int act_max = (1 << (`ANN_DATA_W - 1)) - 1;

	typedef struct packed {
		act_t x0;
		act_t x1;
		logic tie; // reprogram output layer for a tie first
		result_t exp;
	} row_t;

	logic clk;
	logic rst_n;
	weight_wr_t weight_wr;
	input_wr_t input_wr;
	logic start;
	weight_rd_t weight_rd;
	weight_rsp_t weight_rsp;
	result_t result;
	logic busy;

	weight_t wh [n_hid_w];
	weight_t wo [n_out_w];
	act_t cur_x0;
	act_t cur_x1;
	integer seed;
	int cycles;
	int i;
	result_t got;
	result_t exp_res;

	// Q8.8 inputs
	row_t rows [n_rows] = '{
		'{16'sh0100, 16'sh0080, 1'b0, '0}, // 1.0, 0.5
		'{16'shfe80, 16'sh0240, 1'b0, '0}, // -1.5, 2.25
		'{16'sh0000, 16'sh0000, 1'b0, '0}, // biases only
		'{16'shfd00, 16'shff40, 1'b0, '0}, // mostly relu clipped
		'{16'sh6400, 16'sh5a00, 1'b0, '0}, // 100.0 and 90.0 saturate
		'{16'sh8800, 16'sh6e00, 1'b0, '0},
		'{16'sh00c0, 16'shffc0, 1'b1, '0}  // nodes 1 and 2 tie
	};

	main_net main_net_inst (
		.clk(clk),
		.rst_n(rst_n),
		.i_weight_wr(weight_wr),
		.i_input_wr(input_wr),
		.i_start(start),
		.i_weight_rd(weight_rd),
		.o_weight_rsp(weight_rsp),
		.o_result(result),
		.o_busy(busy)
	);

	bind main_net main_net_checker checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.i_weight_rd(i_weight_rd),
		.i_weight_rsp(o_weight_rsp),
		.i_result(o_result),
		.i_busy(o_busy)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: tests did not finish within %0d cycles", cycle_limit);
			stop_run();
		end else if (main_net_inst.checker_inst.n_fail != 0) begin
			$display("assertion failure in the checker at %0t", $time);
			stop_run();
		end
	end

	function automatic act_t scale_sat(acc_t sum);
		acc_t sh;
		sh = sum >>> `ANN_FRAC_W;
		if (sh > acc_t'(act_max)) begin
			return act_t'(act_max);
		end else if (sh < acc_t'(-act_max - 1)) begin
			return act_t'(-act_max - 1);
		end
		return act_t'(sh);
	endfunction

	// bias sits after the node's inputs and multiplies 1.0
	function automatic result_t model(act_t x0, act_t x1);
		act_t x [`ANN_N_IN];
		act_t h [`ANN_N_HID];
		act_t y;
		acc_t sum;
		result_t r;
		int j;
		int k;
		x[0] = x0;
		x[1] = x1;
		for (j = 0; j < `ANN_N_HID; j++) begin
			sum = acc_t'(wh[j * (`ANN_N_IN + 1) + `ANN_N_IN]) * (1 << `ANN_FRAC_W);
			for (k = 0; k < `ANN_N_IN; k++) begin
				sum = sum + acc_t'(wh[j * (`ANN_N_IN + 1) + k]) * acc_t'(x[k]);
			end
			h[j] = scale_sat(sum);
			if (h[j] < 0) begin
				h[j] = '0; // relu
			end
		end
		r = '0;
		r.valid = 1'b1;
		for (j = 0; j < `ANN_N_OUT; j++) begin
			sum = acc_t'(wo[j * (`ANN_N_HID + 1) + `ANN_N_HID]) * (1 << `ANN_FRAC_W);
			for (k = 0; k < `ANN_N_HID; k++) begin
				sum = sum + acc_t'(wo[j * (`ANN_N_HID + 1) + k]) * acc_t'(h[k]);
			end
			y = scale_sat(sum);
			if ((j == 0) || (y > r.value)) begin // ties keep the lower node
				r.arg_max = node_t'(j);
				r.value = y;
			end
		end
		return r;
	endfunction

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_result(result_t got_r, result_t exp_r);
		if (got_r !== exp_r) begin
			$display("[ERROR] %0t: result node %0d value %0d, expected node %0d value %0d",
				$time, got_r.arg_max, got_r.value, exp_r.arg_max, exp_r.value);
			stop_run();
		end
	endtask

	task automatic check_weight_rsp(weight_rsp_t got_w, weight_rsp_t exp_w);
		if (got_w !== exp_w) begin
			$display("[ERROR] %0t: readback valid %0b layer %0d index %0d value %0d",
				$time, got_w.valid, got_w.layer, got_w.waddr, got_w.value);
			$display("[ERROR] %0t: expected valid 1 layer %0d index %0d value %0d",
				$time, exp_w.layer, exp_w.waddr, exp_w.value);
			stop_run();
		end
	endtask

	task automatic write_weight(layer_e l, waddr_t a, weight_t v);
		weight_wr = '{valid: 1'b1, layer: l, waddr: a, value: v};
		if (l == LAYER_HIDDEN) begin
			wh[a] = v;
		end else begin
			wo[a] = v;
		end
		@(negedge clk);
		weight_wr.valid = 1'b0;
	endtask

	task automatic read_check(layer_e l, waddr_t a);
		weight_rsp_t exp_w;
		exp_w = '{valid: 1'b1, layer: l, waddr: a, value: (l == LAYER_HIDDEN) ? wh[a] : wo[a]};
		weight_rd = '{valid: 1'b1, layer: l, waddr: a};
		@(negedge clk);
		weight_rd.valid = 1'b0;
		if (weight_rsp.valid) begin
			$display("readback response came one cycle early at %0t", $time);
			stop_run();
		end
		@(negedge clk);
		check_weight_rsp(weight_rsp, exp_w);
	endtask

	task automatic write_inputs(act_t x0, act_t x1);
		input_wr = '{valid: 1'b1, node: node_t'(0), value: x0};
		@(negedge clk);
		input_wr = '{valid: 1'b1, node: node_t'(1), value: x1};
		@(negedge clk);
		input_wr.valid = 1'b0;
		cur_x0 = x0;
		cur_x1 = x1;
	endtask

	// node 0 pinned to the minimum and node 2 made a copy of node 1
	task automatic make_tie();
		int k;
		for (k = 0; k <= `ANN_N_HID; k++) begin
			write_weight(LAYER_OUTPUT, waddr_t'(k), (k == `ANN_N_HID) ? 16'sh8000 : 16'sh0000);
		end
		for (k = 0; k <= `ANN_N_HID; k++) begin
			write_weight(LAYER_OUTPUT, waddr_t'(2 * (`ANN_N_HID + 1) + k), wo[`ANN_N_HID + 1 + k]);
		end
	endtask

	// poke drives writes, start and a readback while busy
	task automatic run_inference(logic poke, output result_t res);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (!busy) begin
			$display("o_busy did not rise after start at %0t", $time);
			stop_run();
		end
		if (poke) begin
			weight_wr = '{valid: 1'b1, layer: LAYER_HIDDEN, waddr: '0, value: ~wh[0]};
			input_wr = '{valid: 1'b1, node: '0, value: ~cur_x0};
			weight_rd = '{valid: 1'b1, layer: LAYER_HIDDEN, waddr: '0};
			start = 1'b1;
			@(negedge clk);
			weight_wr.valid = 1'b0;
			input_wr.valid = 1'b0;
			weight_rd.valid = 1'b0;
			start = 1'b0;
		end
		while (!result.valid) begin
			if (!busy || weight_rsp.valid) begin
				$display("o_busy low or readback response during inference at %0t", $time);
				stop_run();
			end
			@(negedge clk);
		end
		if (busy) begin
			$display("o_busy still high with the result at %0t", $time);
			stop_run();
		end
		res = result;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		weight_wr = '0;
		input_wr = '0;
		start = 1'b0;
		weight_rd = '0;
		seed = 32'h80c2;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (10) begin
			@(negedge clk);
			if (busy || weight_rsp.valid || result.valid) begin
				$display("output active while idle after reset at %0t", $time);
				stop_run();
			end
		end
		for (i = 0; i < n_hid_w; i++) begin
			write_weight(LAYER_HIDDEN, waddr_t'(i), weight_t'($random(seed) % 513)); // +-2.0
			read_check(LAYER_HIDDEN, waddr_t'(i));
		end
		for (i = 0; i < n_out_w; i++) begin
			write_weight(LAYER_OUTPUT, waddr_t'(i), weight_t'($random(seed) % 513));
			read_check(LAYER_OUTPUT, waddr_t'(i));
		end
		for (i = 0; i < n_rows; i++) begin
			if (rows[i].tie) begin
				make_tie();
			end
			write_inputs(rows[i].x0, rows[i].x1);
			rows[i].exp = model(rows[i].x0, rows[i].x1);
			run_inference(1'b0, got);
			check_result(got, rows[i].exp);
		end
		exp_res = model(cur_x0, cur_x1);
		run_inference(1'b1, got);
		check_result(got, exp_res);
		read_check(LAYER_HIDDEN, '0); // old weight survives
		write_weight(LAYER_OUTPUT, waddr_t'(`ANN_N_HID), 16'sh7fff); // node 0 bias
		exp_res = model(cur_x0, cur_x1);
		run_inference(1'b0, got);
		check_result(got, exp_res);
		if (main_net_inst.checker_inst.n_fail != 0) begin
			$display("%0d assertion failures in the checker", main_net_inst.checker_inst.n_fail);
			stop_run();
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/ann_pkg.sv
rtl/ann_ram.sv
rtl/ann_host_port.sv
rtl/ann_feed_forward.sv
rtl/ann_arg_max.sv
rtl/main_net.sv
dv/main_net_checker.sv
dv/main_net_tb.sv

//--- Bender.yml
package:
  name: main_net

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ann_pkg.sv
      - rtl/ann_ram.sv
      - rtl/ann_host_port.sv
      - rtl/ann_feed_forward.sv
      - rtl/ann_arg_max.sv
      - rtl/main_net.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/main_net_checker.sv
      - dv/main_net_tb.sv
